// File: rtl/cpuPkg.sv
package cpuPkg;

   // Widths fixed by the LEGv8 instruction set
   localparam int dataBits    = 64;
   localparam int regAddrBits = 5;
   // XZR, always reads as zero
   localparam int zeroReg     = 31;
   localparam int instBits    = 32;

   // Supported instructions after prefix match
   typedef enum logic [3:0] {
      opAdd,
      opSub,
      opAdds,
      opSubs,
      opAnd,
      opOrr,
      opAddi,
      opSubi,
      opLdur,
      opStur,
      opLdurb,
      opSturb,
      opMovz,
      opMovk,
      // Anything unrecognised, retired as a no-op
      opIllegal
   } opcodeT;

   // ALU function select, classic datapath encoding
   typedef enum logic [2:0] {
      aluPassB = 3'b000,
      aluAdd   = 3'b010,
      aluSub   = 3'b011,
      aluAnd   = 3'b100,
      aluOr    = 3'b101
   } aluOpT;

   // Data memory req/ack sequencer
   typedef enum logic [1:0] {
      memIdle,
      memRequest,
      memRelease,
      memDone
   } memStateT;

   // Instruction req/ack handshake
   typedef enum logic [1:0] {
      waitReq,
      busy,
      ackHigh,
      waitDrop
   } instStateT;

endpackage

// File: rtl/instrDecode.sv
`timescale 1ns/1ps

module instrDecode import cpuPkg::*; (
   input  logic                   clk,
   input  logic                   rstN,
   // Instruction handshake
   input  logic                   instReq,
   input  logic [instBits-1:0]    instr,
   output logic                   instAck,
   input  logic                   retire,
   // Decoded instruction
   output opcodeT                 opcode,
   output aluOpT                  aluOp,
   output logic [regAddrBits-1:0] rn,
   output logic [regAddrBits-1:0] rm,
   output logic [regAddrBits-1:0] rd,
   output logic [regAddrBits-1:0] readB,
   output logic [11:0]            imm12,
   output logic [8:0]             daddr9,
   output logic [1:0]             shamt,
   output logic [15:0]            imm16,
   // Control bits
   output logic                   regWrite,
   output logic                   memRead,
   output logic                   memWrite,
   output logic                   memByte,
   output logic                   setFlags,
   output logic                   useImm,
   output logic                   useDaddr,
   output logic                   go
);

   instStateT           state;
   logic [instBits-1:0] instrReg;

   // Handshake FSM, go is a one-cycle strobe after acceptance
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= waitReq;
         go    <= 1'b0;
      end else begin
         go <= 1'b0;
         unique case (state)
            waitReq: begin
               if (instReq) begin
                  state <= busy;
                  go    <= 1'b1;
               end
            end
            busy: begin
               if (retire)
                  state <= ackHigh;
            end
            ackHigh: begin
               if (!instReq)
                  state <= waitDrop;
            end
            // One quiet cycle with ack low before the next request
            waitDrop: state <= waitReq;
         endcase
      end
   end

   // Word is held until the next acceptance
   always_ff @(posedge clk) begin
      if (state == waitReq && instReq)
         instrReg <= instr;
   end

   assign instAck = (state == ackHigh);

   // Field slices, meaning depends on format
   assign rd     = instrReg[4:0];
   assign rn     = instrReg[9:5];
   assign rm     = instrReg[20:16];
   assign imm12  = instrReg[21:10];
   assign daddr9 = instrReg[20:12];
   assign imm16  = instrReg[20:5];
   assign shamt  = instrReg[22:21];

   // Match 11, 10 and 9 bit prefixes
   always_comb begin
      casez (instrReg[31:21])
         11'b10001011000: opcode = opAdd;
         11'b11001011000: opcode = opSub;
         11'b10101011000: opcode = opAdds;
         11'b11101011000: opcode = opSubs;
         11'b10001010000: opcode = opAnd;
         11'b10101010000: opcode = opOrr;
         11'b1001000100?: opcode = opAddi;
         11'b1101000100?: opcode = opSubi;
         11'b11111000010: opcode = opLdur;
         11'b11111000000: opcode = opStur;
         11'b00111000010: opcode = opLdurb;
         11'b00111000000: opcode = opSturb;
         11'b110100101??: opcode = opMovz;
         11'b111100101??: opcode = opMovk;
         default:         opcode = opIllegal;
      endcase
   end

   // Loads and stores add the offset to the base
   always_comb begin
      case (opcode)
         opSub, opSubs, opSubi:     aluOp = aluSub;
         opAnd:                     aluOp = aluAnd;
         opOrr:                     aluOp = aluOr;
         opMovz, opMovk, opIllegal: aluOp = aluPassB;
         default:                   aluOp = aluAdd;
      endcase
   end

   assign regWrite = !(opcode inside {opStur, opSturb, opIllegal});
   assign memRead  = opcode inside {opLdur, opLdurb};
   assign memWrite = opcode inside {opStur, opSturb};
   assign memByte  = opcode inside {opLdurb, opSturb};
   assign setFlags = opcode inside {opAdds, opSubs};
   assign useImm   = opcode inside {opAddi, opSubi};
   assign useDaddr = memRead || memWrite;

   // Reg2Loc, Rd is needed as store data and as the MOVK base
   assign readB = (memWrite || opcode == opMovk) ? rd : rm;

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
   input  logic                   clk,
   input  logic [regAddrBits-1:0] readAddrA,
   input  logic [regAddrBits-1:0] readAddrB,
   output logic [dataBits-1:0]    readDataA,
   output logic [dataBits-1:0]    readDataB,
   input  logic [regAddrBits-1:0] writeAddr,
   input  logic [dataBits-1:0]    writeData,
   input  logic                   writeEn
);

   logic [dataBits-1:0] regs [1 << regAddrBits];

   // Combinational reads, XZR forced to zero
   assign readDataA = (readAddrA == zeroReg) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == zeroReg) ? '0 : regs[readAddrB];

   // Writes to XZR are dropped
   always_ff @(posedge clk) begin
      if (writeEn && writeAddr != zeroReg)
         regs[writeAddr] <= writeData;
   end

endmodule

// File: rtl/execUnit.sv
`timescale 1ns/1ps

module execUnit import cpuPkg::*; (
   input  logic                clk,
   input  logic                rstN,
   input  logic                go,
   input  opcodeT              opcode,
   input  aluOpT               aluOp,
   input  logic                setFlags,
   input  logic                useImm,
   input  logic                useDaddr,
   input  logic [11:0]         imm12,
   input  logic [8:0]          daddr9,
   input  logic [1:0]          shamt,
   input  logic [15:0]         imm16,
   input  logic [dataBits-1:0] regA,
   input  logic [dataBits-1:0] regB,
   output logic [dataBits-1:0] aluResult,
   output logic [dataBits-1:0] storeData,
   output logic [3:0]          flags
);

   logic [dataBits-1:0] daddrExt;
   logic [dataBits-1:0] imm12Ext;
   logic [5:0]          laneShift;
   logic [dataBits-1:0] laneMask;
   logic [dataBits-1:0] imm16Shifted;
   logic [dataBits-1:0] movkMerge;
   logic [dataBits-1:0] opB;
   logic [dataBits-1:0] addB;
   logic [dataBits-1:0] sum;
   logic                carryOut;
   logic                overflow;

   // Offset is signed, arithmetic immediate is not
   assign daddrExt = {{(dataBits - 9){daddr9[8]}}, daddr9};
   assign imm12Ext = {{(dataBits - 12){1'b0}}, imm12};

   // Lane select, shamt times 16
   assign laneShift    = {shamt, 4'b0000};
   assign laneMask     = {{(dataBits - 16){1'b0}}, 16'hFFFF} << laneShift;
   assign imm16Shifted = {{(dataBits - 16){1'b0}}, imm16} << laneShift;

   // MOVK keeps the other three lanes of Rd
   assign movkMerge = (regB & ~laneMask) | imm16Shifted;

   // Second operand mux chain
   always_comb begin
      if (opcode == opMovz)
         opB = imm16Shifted;
      else if (opcode == opMovk)
         opB = movkMerge;
      else if (useImm)
         opB = imm12Ext;
      else if (useDaddr)
         opB = daddrExt;
      else
         opB = regB;
   end

   // Subtract as A plus inverted B plus one, carry is NOT borrow
   assign addB              = (aluOp == aluSub) ? ~opB : opB;
   assign {carryOut, sum}   = {1'b0, regA} + {1'b0, addB} + (aluOp == aluSub);
   // Signed overflow when operand signs agree and the sum sign differs
   assign overflow = (regA[dataBits-1] == addB[dataBits-1]) &&
                     (sum[dataBits-1] != regA[dataBits-1]);

   always_comb begin
      case (aluOp)
         aluAdd,
         aluSub:  aluResult = sum;
         aluAnd:  aluResult = regA & opB;
         aluOr:   aluResult = regA | opB;
         default: aluResult = opB;
      endcase
   end

   // NZVC, updated only by ADDS and SUBS
   always_ff @(posedge clk) begin
      if (!rstN)
         flags <= 4'b0000;
      else if (go && setFlags)
         flags <= {aluResult[dataBits-1], aluResult == '0, overflow, carryOut};
   end

   assign storeData = regB;

endmodule

// File: rtl/resultUnit.sv
`timescale 1ns/1ps

module resultUnit import cpuPkg::*; (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic                   go,
   input  logic                   memRead,
   input  logic                   memWrite,
   input  logic                   memByte,
   input  logic                   regWrite,
   input  logic [regAddrBits-1:0] rd,
   input  logic [dataBits-1:0]    aluResult,
   input  logic [dataBits-1:0]    storeData,
   // Data memory port
   output logic                   memReq,
   output logic                   memWriteOut,
   output logic                   memByteOut,
   output logic [dataBits-1:0]    memAddr,
   output logic [dataBits-1:0]    memWData,
   input  logic [dataBits-1:0]    memRData,
   input  logic                   memAck,
   // Register write port
   output logic [regAddrBits-1:0] wbAddr,
   output logic [dataBits-1:0]    wbData,
   output logic                   wbEn,
   output logic                   retire
);

   memStateT            state;
   logic [dataBits-1:0] loadData;
   logic                memAccess;

   assign memAccess = memRead || memWrite;

   // Four-phase sequencer, waits on ack with no timeout
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= memIdle;
      end else begin
         unique case (state)
            memIdle: begin
               if (go && memAccess)
                  state <= memRequest;
            end
            memRequest: begin
               if (memAck)
                  state <= memRelease;
            end
            memRelease: begin
               if (!memAck)
                  state <= memDone;
            end
            memDone: state <= memIdle;
         endcase
      end
   end

   // Request payload held stable for the whole exchange
   always_ff @(posedge clk) begin
      if (state == memIdle && go && memAccess) begin
         memAddr     <= aluResult;
         memWData    <= storeData;
         memWriteOut <= memWrite;
         memByteOut  <= memByte;
      end
   end

   // Read data taken on the first ack cycle, LDURB keeps the low byte
   always_ff @(posedge clk) begin
      if (state == memRequest && memAck)
         loadData <= memByte ? {{(dataBits - 8){1'b0}}, memRData[7:0]} : memRData;
   end

   assign memReq = (state == memRequest);

   // Non-memory ops retire on the go cycle
   assign retire = (state == memDone) || (state == memIdle && go && !memAccess);
   assign wbEn   = retire && regWrite;
   assign wbAddr = rd;
   assign wbData = (state == memDone) ? loadData : aluResult;

endmodule

// File: rtl/armCore.sv
`timescale 1ns/1ps

module armCore import cpuPkg::*; (
   input  logic                clk,
   input  logic                rstN,
   // Instruction port
   input  logic                instReq,
   input  logic [instBits-1:0] instr,
   output logic                instAck,
   output logic [3:0]          flags,
   // Data memory port
   output logic                memReq,
   output logic                memWrite,
   output logic                memByte,
   output logic [dataBits-1:0] memAddr,
   output logic [dataBits-1:0] memWData,
   input  logic [dataBits-1:0] memRData,
   input  logic                memAck
);

   opcodeT                 opcode;
   aluOpT                  aluOp;
   logic [regAddrBits-1:0] rn;
   logic [regAddrBits-1:0] rd;
   logic [regAddrBits-1:0] readB;
   logic [11:0]            imm12;
   logic [8:0]             daddr9;
   logic [1:0]             shamt;
   logic [15:0]            imm16;
   logic                   regWrite;
   logic                   decMemRead;
   logic                   decMemWrite;
   logic                   decMemByte;
   logic                   setFlags;
   logic                   useImm;
   logic                   useDaddr;
   logic                   go;
   logic                   retire;
   logic [dataBits-1:0]    regA;
   logic [dataBits-1:0]    regB;
   logic [dataBits-1:0]    aluResult;
   logic [dataBits-1:0]    storeData;
   logic [regAddrBits-1:0] wbAddr;
   logic [dataBits-1:0]    wbData;
   logic                   wbEn;

   // Rm only feeds the Reg2Loc select inside decode
   instrDecode u_decode (
      .clk, .rstN, .instReq, .instr, .instAck, .retire,
      .opcode, .aluOp, .rn, .rm(), .rd, .readB,
      .imm12, .daddr9, .shamt, .imm16, .regWrite,
      .memRead(decMemRead), .memWrite(decMemWrite), .memByte(decMemByte),
      .setFlags, .useImm, .useDaddr, .go
   );

   regFile u_regs (
      .clk,
      .readAddrA(rn),
      .readAddrB(readB),
      .readDataA(regA),
      .readDataB(regB),
      .writeAddr(wbAddr),
      .writeData(wbData),
      .writeEn(wbEn)
   );

   execUnit u_exec (
      .clk, .rstN, .go, .opcode, .aluOp, .setFlags, .useImm, .useDaddr,
      .imm12, .daddr9, .shamt, .imm16, .regA, .regB,
      .aluResult, .storeData, .flags
   );

   // Write-back and memory sequencing
   resultUnit u_result (
      .clk, .rstN, .go,
      .memRead(decMemRead), .memWrite(decMemWrite), .memByte(decMemByte),
      .regWrite, .rd, .aluResult, .storeData,
      .memReq, .memWriteOut(memWrite), .memByteOut(memByte),
      .memAddr, .memWData, .memRData, .memAck,
      .wbAddr, .wbData, .wbEn, .retire
   );

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
   output logic clk,
   output logic rstN
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset low for five rising edges, released on a falling edge
   initial begin
      rstN = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
   end

endmodule

// File: testbench/armCore_properties.sv
`timescale 1ns/1ps

module armCoreProperties import cpuPkg::*; (
   input logic                clk,
   input logic                rstN,
   input logic                instReq,
   input logic                instAck,
   input logic                memReq,
   input logic                memAck,
   input logic [dataBits-1:0] memAddr
);

   // Read by the testbench at the end of the run
   int failCount = 0;

   // Request and address held until the memory answers
   memHold: assert property (@(posedge clk) disable iff (!rstN)
      memReq && !memAck |=> memReq && $stable(memAddr))
      else begin
         $error("memReq or memAddr changed before memAck was seen");
         failCount++;
      end

   // Ack only answers a pending request
   ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
      !instReq && !instAck |=> !instAck)
      else begin
         $error("instAck rose while instReq was low");
         failCount++;
      end

   // Both outputs quiet while in reset
   resetQuiet: assert property (@(posedge clk)
      !rstN |=> !instAck && !memReq)
      else begin
         $error("instAck or memReq high during reset");
         failCount++;
      end

endmodule

bind armCore armCoreProperties u_props (.*);

// File: testbench/armCoreTb.sv
`timescale 1ns/1ps

module armCoreTb import cpuPkg::*; ();

   logic                clk;
   logic                rstN;
   logic                instReq;
   logic [instBits-1:0] instr;
   logic                instAck;
   logic [3:0]          flags;
   logic                memReq;
   logic                memWrite;
   logic                memByte;
   logic [dataBits-1:0] memAddr;
   logic [dataBits-1:0] memWData;
   logic [dataBits-1:0] memRData;
   logic                memAck;

   // One entry per stimulus line
   logic [31:0] instrQ[$];
   logic [1:0]  kindQ[$];
   logic [63:0] addrQ[$];
   logic [63:0] wdataQ[$];
   logic        byteQ[$];
   logic [63:0] rdataQ[$];
   logic [3:0]  flagsQ[$];

   int curLine    = 0;
   int memCount   = 0;
   int errorCount = 0;
   int checkCount = 0;

   clockGen u_clock (.clk, .rstN);

   armCore u_dut (
      .clk, .rstN, .instReq, .instr, .instAck, .flags,
      .memReq, .memWrite, .memByte, .memAddr, .memWData, .memRData, .memAck
   );

   task automatic checkValue(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic loadStimulus(input int fd);
      string       line;
      int          fields;
      logic [31:0] word;
      logic [63:0] kind;
      logic [63:0] addr;
      logic [63:0] wdata;
      logic [63:0] byteFlag;
      logic [63:0] rdata;
      logic [63:0] flagBits;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // Comment lines start with a hash
         if (line.len() > 0 && line[0] != "#") begin
            fields = $sscanf(line, "%h %h %h %h %h %h %h",
                             word, kind, addr, wdata, byteFlag, rdata, flagBits);
            if (fields == 7) begin
               instrQ.push_back(word);
               kindQ.push_back(kind[1:0]);
               addrQ.push_back(addr);
               wdataQ.push_back(wdata);
               byteQ.push_back(byteFlag[0]);
               rdataQ.push_back(rdata);
               flagsQ.push_back(flagBits[3:0]);
            end
         end
      end
      $fclose(fd);
   endtask

   // Compare a memory request against the current stimulus line
   task automatic checkAccess();
      logic [63:0] mask;
      memCount++;
      if (kindQ[curLine] == 2'd0) begin
         errorCount++;
         $display("Unexpected memory access at %0t for stimulus line %0d", $time, curLine);
      end else begin
         // Only the low byte matters for a byte store
         mask = byteQ[curLine] ? 64'hFF : '1;
         checkValue("memWrite", kindQ[curLine] == 2'd2, memWrite);
         checkValue("memByte", byteQ[curLine], memByte);
         checkValue("memAddr", addrQ[curLine], memAddr);
         if (kindQ[curLine] == 2'd2)
            checkValue("memWData", wdataQ[curLine] & mask, memWData & mask);
      end
   endtask

   // Called on a falling edge and returns once instAck has dropped
   task automatic runInstruction(input int idx);
      int cycles;
      int memBefore;
      cycles    = 0;
      memBefore = memCount;
      curLine   = idx;
      instr     = instrQ[idx];
      instReq   = 1'b1;
      do begin
         @(negedge clk);
         cycles++;
      end while (!instAck);
      if (kindQ[idx] == 2'd0)
         checkValue("instAck latency", 64'd2, cycles);
      checkValue("flags", flagsQ[idx], flags);
      checkValue("memory access count", memBefore + (kindQ[idx] != 2'd0), memCount);
      instReq = 1'b0;
      while (instAck)
         @(negedge clk);
   endtask

   // Ends the run if the core stops answering
   task automatic hangTimer(input int lines);
      #((lines * 40 + 10) * 4);
      $display("Watchdog expired: the core stopped answering on a handshake");
      $display("Checks: %0d  errors: %0d", checkCount, errorCount + 1);
      $display("** FAIL **");
      $finish;
   endtask

   // Data memory with 0 to 3 cycles of random latency
   initial begin : dataMemory
      int delay;
      memAck   = 1'b0;
      memRData = '0;
      // Fixed seed for the ack delays
      void'($urandom(15));
      forever begin
         @(negedge clk);
         if (rstN && memReq && !memAck) begin
            checkAccess();
            delay = $urandom % 4;
            repeat (delay) @(negedge clk);
            memRData = rdataQ[curLine];
            memAck   = 1'b1;
            do @(negedge clk); while (memReq);
            memAck = 1'b0;
         end
      end
   end

   initial begin : mainFlow
      int fd;
      int totalErrors;
      instReq = 1'b0;
      instr   = '0;
      fd      = $fopen("testbench/program_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open testbench/program_stim.txt");
         $display("** FAIL **");
         $finish;
      end else begin
         loadStimulus(fd);
         if (instrQ.size() == 0) begin
            errorCount++;
            $display("Stimulus file holds no instructions");
         end
         fork
            hangTimer(instrQ.size());
         join_none
         @(posedge rstN);
         foreach (instrQ[i]) begin
            @(negedge clk);
            runInstruction(i);
         end
         repeat (4) @(negedge clk);
         totalErrors = errorCount + u_dut.u_props.failCount;
         $display("Checks: %0d  errors: %0d  assertion failures: %0d",
                  checkCount, errorCount, u_dut.u_props.failCount);
         if (totalErrors == 0)
            $display("** PASS **");
         else
            $display("** FAIL **");
         $finish;
      end
   end

endmodule

// File: testbench/program_stim.txt
# instr kind(0 none 1 read 2 write) addr wdata byte rdata flags(NZVC), all hex
# Build X1 lane by lane, base X2, then stores at X2 plus offset
D2E24681 0 000 0000000000000000 0 0000000000000000 0
F2CACF01 0 000 0000000000000000 0 0000000000000000 0
F2B35781 0 000 0000000000000000 0 0000000000000000 0
F29BDE01 0 000 0000000000000000 0 0000000000000000 0
D2802002 0 000 0000000000000000 0 0000000000000000 0
F8008041 2 108 123456789ABCDEF0 0 0000000000000000 0
F81F0041 2 0F0 123456789ABCDEF0 0 0000000000000000 0
D2801E03 0 000 0000000000000000 0 0000000000000000 0
D281E1E4 0 000 0000000000000000 0 0000000000000000 0
8B040065 0 000 0000000000000000 0 0000000000000000 0
CB040066 0 000 0000000000000000 0 0000000000000000 0
8A040027 0 000 0000000000000000 0 0000000000000000 0
AA040068 0 000 0000000000000000 0 0000000000000000 0
91048C69 0 000 0000000000000000 0 0000000000000000 0
D104006A 0 000 0000000000000000 0 0000000000000000 0
F8010045 2 110 0000000000000FFF 0 0000000000000000 0
F8018046 2 118 FFFFFFFFFFFFF1E1 0 0000000000000000 0
F8020047 2 120 0000000000000E00 0 0000000000000000 0
F8028048 2 128 0000000000000FFF 0 0000000000000000 0
F8030049 2 130 0000000000000213 0 0000000000000000 0
F803804A 2 138 FFFFFFFFFFFFFFF0 0 0000000000000000 0
AB04006B 0 000 0000000000000000 0 0000000000000000 0
EB03006C 0 000 0000000000000000 0 0000000000000000 5
EB04006D 0 000 0000000000000000 0 0000000000000000 8
D2EFFFEE 0 000 0000000000000000 0 0000000000000000 8
AB0E01CF 0 000 0000000000000000 0 0000000000000000 A
AB0F01F0 0 000 0000000000000000 0 0000000000000000 9
F807804F 2 178 FFFE000000000000 0 0000000000000000 9
F8440051 1 140 0000000000000000 0 A5A55A5A01234567 9
38448052 1 148 0000000000000000 1 FFEEDDCCBBAA9987 9
F8050051 2 150 A5A55A5A01234567 0 0000000000000000 9
F8058052 2 158 0000000000000087 0 0000000000000000 9
38060041 2 160 123456789ABCDEF0 1 0000000000000000 9
D28AAABF 0 000 0000000000000000 0 0000000000000000 9
8B0303F3 0 000 0000000000000000 0 0000000000000000 9
F8068053 2 168 00000000000000F0 0 0000000000000000 9
F807005F 2 170 0000000000000000 0 0000000000000000 9

// File: verilog.f
rtl/cpuPkg.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/resultUnit.sv
rtl/armCore.sv
testbench/clockGen.sv
testbench/armCore_properties.sv
testbench/armCoreTb.sv
